//--- rtl/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // Upper nibble of every control byte addressed to this device.
    localparam logic [3:0] DEV_CODE = 4'b1010;

    localparam int ADDR_W    = 11;   // 3 block bits plus 8 byte bits.
    localparam int MEM_DEPTH = 2048; // Eight blocks of 256 bytes.

    // Protocol engine states.
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CTRL,       // Receive control byte.
        ST_CTRL_ACK,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_WDATA,
        ST_WDATA_ACK,
        ST_RDATA,      // Shift out byte.
        ST_RDATA_ACK   // Sample master acknowledge.
    } i2c_state_e;

endpackage

`default_nettype wire

//--- rtl/line_sync.sv
`timescale 1ns/1ps
`default_nettype none

module line_sync
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic arst_n,
    input  logic i2c_clk,
    input  logic i2c_data_in,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det,
    output logic data_bit
);

    logic clk_s1, clk_s2, clk_q;
    logic dat_s1, dat_s2, dat_q;

    // Both lines idle high, so the flops reset high to avoid a false start.
    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_s1 <= 1'b1;
            clk_s2 <= 1'b1;
            clk_q  <= 1'b1;
            dat_s1 <= 1'b1;
            dat_s2 <= 1'b1;
            dat_q  <= 1'b1;
        end
        else
        begin
            clk_s1 <= i2c_clk;
            clk_s2 <= clk_s1;
            clk_q  <= clk_s2;
            dat_s1 <= i2c_data_in;
            dat_s2 <= dat_s1;
            dat_q  <= dat_s2;
        end
    end

    // Edge register. Outputs line up three cycles after the pins.
    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
            data_bit  <= 1'b1;
        end
        else
        begin
            scl_rise  <= clk_s2 & ~clk_q;
            scl_fall  <= ~clk_s2 & clk_q;
            start_det <= clk_s2 & clk_q & dat_q & ~dat_s2; // Data falls, clock high.
            stop_det  <= clk_s2 & clk_q & ~dat_q & dat_s2; // Data rises, clock high.
            data_bit  <= dat_s2;
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2c_slave_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_fsm
    import eeprom_pkg::*;
(
    input  logic              sda,
    input  logic              arst_n,
    input  logic              scl_rise,
    input  logic              scl_fall,
    input  logic              start_det,
    input  logic              stop_det,
    input  logic              data_bit,
    input  logic [7:0]        mem_rdata,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [7:0]        mem_wdata,
    output logic              mem_we,
    output logic              mem_re,
    output logic              i2c_data_oe
);

    i2c_state_e state;
    logic [3:0] bit_cnt;
    logic [7:0] shift_reg;
    logic [7:0] tx_byte;
    logic [2:0] blk_bits;
    logic [7:0] addr_lo;
    logic       ctrl_rd;   // Read bit of the accepted control byte.
    logic       rd_pend;   // Memory read data arrives this cycle.
    logic       rx_state;
    logic       rx_shift;
    logic       byte_done;
    logic       ctrl_ok;

    assign rx_state  = (state == ST_CTRL) || (state == ST_ADDR) || (state == ST_WDATA);
    assign rx_shift  = rx_state && scl_rise && (bit_cnt != 4'd8);
    assign byte_done = scl_fall && (bit_cnt == 4'd8);
    assign ctrl_ok   = (shift_reg[7:4] == DEV_CODE);

    assign mem_addr  = {blk_bits, addr_lo};
    assign mem_wdata = shift_reg;

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= ST_IDLE;
            bit_cnt     <= 4'd0;
            i2c_data_oe <= 1'b0;
            mem_we      <= 1'b0;
            mem_re      <= 1'b0;
            rd_pend     <= 1'b0;
        end
        else
        begin
            mem_we  <= 1'b0;
            mem_re  <= 1'b0;
            rd_pend <= mem_re;
            if (start_det)
            begin
                state       <= ST_CTRL;   // Also covers the repeated start.
                bit_cnt     <= 4'd0;
                i2c_data_oe <= 1'b0;
            end
            else if (stop_det)
            begin
                state       <= ST_IDLE;
                bit_cnt     <= 4'd0;
                i2c_data_oe <= 1'b0;
            end
            else
            begin
                case (state)
                    ST_IDLE:
                    begin
                        bit_cnt <= 4'd0;
                    end
                    ST_CTRL:
                    begin
                        if (rx_shift)
                            bit_cnt <= bit_cnt + 4'd1;
                        else if (byte_done)
                        begin
                            if (ctrl_ok)
                            begin
                                state       <= ST_CTRL_ACK;
                                i2c_data_oe <= 1'b1;
                                mem_re      <= shift_reg[0]; // Fetch early for a read.
                            end
                            else
                            begin
                                state   <= ST_IDLE; // Not our device code.
                                bit_cnt <= 4'd0;
                            end
                        end
                    end
                    ST_ADDR:
                    begin
                        if (rx_shift)
                            bit_cnt <= bit_cnt + 4'd1;
                        else if (byte_done)
                        begin
                            state       <= ST_ADDR_ACK;
                            i2c_data_oe <= 1'b1;
                        end
                    end
                    ST_WDATA:
                    begin
                        if (rx_shift)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd7)
                                mem_we <= 1'b1;
                        end
                        else if (byte_done)
                        begin
                            state       <= ST_WDATA_ACK;
                            i2c_data_oe <= 1'b1;
                        end
                    end
                    ST_CTRL_ACK:
                    begin
                        if (scl_fall)
                        begin
                            bit_cnt <= 4'd0;
                            if (ctrl_rd)
                            begin
                                state       <= ST_RDATA;
                                i2c_data_oe <= ~tx_byte[7]; // MSB goes out first.
                            end
                            else
                            begin
                                state       <= ST_ADDR;
                                i2c_data_oe <= 1'b0;
                            end
                        end
                    end
                    ST_ADDR_ACK:
                    begin
                        if (scl_fall)
                        begin
                            state       <= ST_WDATA;
                            bit_cnt     <= 4'd0;
                            i2c_data_oe <= 1'b0;
                        end
                    end
                    ST_WDATA_ACK:
                    begin
                        if (scl_fall)
                        begin
                            state       <= ST_IDLE; // Single byte writes only.
                            bit_cnt     <= 4'd0;
                            i2c_data_oe <= 1'b0;
                        end
                    end
                    ST_RDATA:
                    begin
                        if (scl_fall)
                        begin
                            if (bit_cnt == 4'd7)
                            begin
                                state       <= ST_RDATA_ACK;
                                bit_cnt     <= 4'd0;
                                i2c_data_oe <= 1'b0; // Let the master drive the ack.
                            end
                            else
                            begin
                                bit_cnt     <= bit_cnt + 4'd1;
                                i2c_data_oe <= ~tx_byte[6];
                            end
                        end
                    end
                    ST_RDATA_ACK:
                    begin
                        // No sequential reads, so ack and nack both end the read.
                        if (scl_rise)
                            state <= ST_IDLE;
                    end
                    default:
                    begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // Shift register, captured address and outgoing byte.
    always_ff @(posedge sda)
    begin
        if (rx_shift)
            shift_reg <= {shift_reg[6:0], data_bit};
        if ((state == ST_CTRL) && byte_done && ctrl_ok)
        begin
            ctrl_rd <= shift_reg[0];
            if (!shift_reg[0])
                blk_bits <= shift_reg[3:1]; // Read keeps the stored block.
        end
        if ((state == ST_ADDR) && byte_done)
            addr_lo <= shift_reg;
        if (rd_pend)
            tx_byte <= mem_rdata;
        else if ((state == ST_RDATA) && scl_fall)
            tx_byte <= {tx_byte[6:0], 1'b0};
    end

    a_idle_released: assert property (@(posedge sda) disable iff (!arst_n)
        (state == ST_IDLE) |-> !i2c_data_oe);

    a_we_after_last_bit: assert property (@(posedge sda) disable iff (!arst_n)
        mem_we |-> $past((state == ST_WDATA) && scl_rise && (bit_cnt == 4'd7)));

    a_we_re_exclusive: assert property (@(posedge sda) disable iff (!arst_n)
        !(mem_we && mem_re));

endmodule

`default_nettype wire

//--- rtl/eeprom_mem.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_mem
    import eeprom_pkg::*;
(
    input  logic              sda,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [7:0]        mem_wdata,
    input  logic              mem_we,
    input  logic              mem_re,
    output logic [7:0]        mem_rdata
);

    // Eight blocks of 256 bytes with the block number in the top address bits.
    logic [7:0] mem_array [MEM_DEPTH];

    always_ff @(posedge sda)
    begin
        if (mem_we)
            mem_array[mem_addr] <= mem_wdata;
    end

    // Registered read port. Data is valid the cycle after mem_re.
    always_ff @(posedge sda)
    begin
        if (mem_re)
            mem_rdata <= mem_array[mem_addr];
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_i2c_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_top
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic arst_n,
    input  logic i2c_clk,
    input  logic i2c_data_in,
    output logic i2c_data_oe
);

    logic              scl_rise;
    logic              scl_fall;
    logic              start_det;
    logic              stop_det;
    logic              data_bit;
    logic [ADDR_W-1:0] mem_addr;
    logic [7:0]        mem_wdata;
    logic [7:0]        mem_rdata;
    logic              mem_we;
    logic              mem_re;

    line_sync u_line_sync (
        .sda         (sda),
        .arst_n      (arst_n),
        .i2c_clk     (i2c_clk),
        .i2c_data_in (i2c_data_in),
        .scl_rise    (scl_rise),
        .scl_fall    (scl_fall),
        .start_det   (start_det),
        .stop_det    (stop_det),
        .data_bit    (data_bit)
    );

    i2c_slave_fsm u_fsm (
        .sda         (sda),
        .arst_n      (arst_n),
        .scl_rise    (scl_rise),
        .scl_fall    (scl_fall),
        .start_det   (start_det),
        .stop_det    (stop_det),
        .data_bit    (data_bit),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .i2c_data_oe (i2c_data_oe)   // Open drain pull-low enable.
    );

    eeprom_mem u_mem (
        .sda       (sda),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- tb/i2c_master_tasks.svh
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// Bus master tasks. Every change lands 1 ns after a rising sda edge.
// After each task the clock is low and HOLD cycles past its falling edge,
// except stop_condition, which leaves the bus idle.

task automatic wait_cycles(input int n);
    repeat (n)
        @(posedge sda);
    #1;
endtask

// One clock high phase, then low until the data may change.
task automatic clock_pulse();
    i2c_clk = 1'b1;
    wait_cycles(HALF);
    i2c_clk = 1'b0;
    wait_cycles(HOLD);
endtask

task automatic start_condition();
    if (!i2c_clk)
    begin
        master_low = 1'b0;        // Release data first for a repeated start.
        wait_cycles(HALF - HOLD);
        i2c_clk = 1'b1;
        wait_cycles(HALF);
    end
    master_low = 1'b1;            // Data falls while the clock is high.
    wait_cycles(HALF);
    i2c_clk = 1'b0;
    wait_cycles(HOLD);
endtask

task automatic stop_condition();
    master_low = 1'b1;
    wait_cycles(HALF - HOLD);
    i2c_clk = 1'b1;
    wait_cycles(HALF);
    master_low = 1'b0;            // Data rises while the clock is high.
    wait_cycles(HALF);
endtask

// Eight bits MSB first, then the ninth clock with the line released.
task automatic send_byte(input logic [7:0] value, output logic ack);
    int i;
    for (i = 7; i >= 0; i--)
    begin
        master_low = ~value[i];
        wait_cycles(HALF - HOLD);
        clock_pulse();
    end
    master_low = 1'b0;
    wait_cycles(HALF - HOLD);
    i2c_clk = 1'b1;
    wait_cycles(HALF - 1);
    ack = ~i2c_data_in;           // Low line in the ninth clock.
    wait_cycles(1);
    i2c_clk = 1'b0;
    wait_cycles(HOLD);
endtask

// Samples each bit late in the high phase; ack set pulls the ninth bit low.
task automatic recv_byte(input logic ack, output logic [7:0] value);
    int i;
    master_low = 1'b0;
    for (i = 7; i >= 0; i--)
    begin
        wait_cycles(HALF - HOLD);
        i2c_clk = 1'b1;
        wait_cycles(HALF - 1);
        value[i] = i2c_data_in;
        wait_cycles(1);
        i2c_clk = 1'b0;
        wait_cycles(HOLD);
    end
    master_low = ack;
    wait_cycles(HALF - HOLD);
    clock_pulse();
endtask

`endif

//--- tb/eeprom_i2c_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_tb
    import eeprom_pkg::*;
();

    localparam int HALF       = 20;          // Bus half period in sda cycles.
    localparam int HOLD       = 4;           // Data change after clock fall.
    localparam int BIT_CYCLES = 2 * HALF;
    // About 46 transactions of at most 41 bus bits each, with margin.
    localparam int TIMEOUT_CYCLES = 50 * 45 * BIT_CYCLES;
    localparam logic [31:0] LCG_SEED = 32'h58ded908;

    logic sda;
    logic arst_n;
    logic i2c_clk;
    logic master_low;
    logic i2c_data_in;
    logic i2c_data_oe;

    logic [7:0]  shadow_mem [MEM_DEPTH];
    int          value_errors = 0;
    int          ack_errors = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state;

    // The data line is pulled up and reads low when either side pulls.
    assign i2c_data_in = ~(master_low | i2c_data_oe);

    eeprom_i2c_top u_eeprom_i2c_top (
        .sda         (sda),
        .arst_n      (arst_n),
        .i2c_clk     (i2c_clk),
        .i2c_data_in (i2c_data_in),
        .i2c_data_oe (i2c_data_oe)
    );

    `include "i2c_master_tasks.svh"

    initial
    begin
        sda = 1'b0;
        forever
            #5 sda = ~sda;
    end

    always @(posedge sda)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("FAIL time=%0t %s expected=%02h actual=%02h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic report_missing_ack(input string what, input logic [ADDR_W-1:0] addr);
        $display("No acknowledge on the %s for address %03h at %0t", what, addr, $time);
        ack_errors++;
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        logic ack;
        start_condition();
        send_byte({DEV_CODE, addr[10:8], 1'b0}, ack);
        if (!ack)
            report_missing_ack("write control byte", addr);
        send_byte(addr[7:0], ack);
        if (!ack)
            report_missing_ack("address byte", addr);
        send_byte(data, ack);
        if (!ack)
            report_missing_ack("data byte", addr);
        stop_condition();
        shadow_mem[addr] = data;
    endtask

    // Random read with a dummy address write, repeated start, one byte and nack.
    task automatic read_byte(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
        logic ack;
        start_condition();
        send_byte({DEV_CODE, addr[10:8], 1'b0}, ack);
        if (!ack)
            report_missing_ack("write control byte", addr);
        send_byte(addr[7:0], ack);
        if (!ack)
            report_missing_ack("address byte", addr);
        start_condition();
        send_byte({DEV_CODE, addr[10:8], 1'b1}, ack);
        if (!ack)
            report_missing_ack("read control byte", addr);
        recv_byte(1'b0, data);
        stop_condition();
    endtask

    task automatic verify_location(input logic [ADDR_W-1:0] addr);
        logic [7:0] got;
        read_byte(addr, got);
        if (got !== shadow_mem[addr])
            report_mismatch($sformatf("read data at %03h", addr), shadow_mem[addr], got);
    endtask

    task automatic check_idle_release();
        int i;
        for (i = 0; i < 40; i++)
        begin
            if (i2c_data_oe !== 1'b0)
                report_mismatch("i2c_data_oe", 8'h00, {7'b0, i2c_data_oe});
            wait_cycles(1);
        end
    endtask

    task automatic write_then_read();
        write_byte(11'h123, 8'hA5);
        verify_location(11'h123);
    endtask

    // Same byte address in blocks 2 and 5.
    task automatic block_bits_mapping();
        write_byte({3'd2, 8'h5A}, 8'h3C);
        write_byte({3'd5, 8'h5A}, 8'hC3);
        verify_location({3'd2, 8'h5A});
        verify_location({3'd5, 8'h5A});
    endtask

    task automatic reject_wrong_code();
        logic ack;
        start_condition();
        send_byte({4'b1011, 3'd1, 1'b0}, ack);
        if (ack)
        begin
            $display("Acknowledge on a wrong device code at %0t", $time);
            ack_errors++;
        end
        send_byte(8'h23, ack);
        send_byte(8'h00, ack);
        if (ack)
        begin
            $display("Acknowledge on a data byte after a wrong device code at %0t", $time);
            ack_errors++;
        end
        stop_condition();
        verify_location(11'h123);
    endtask

    task automatic abort_write_on_stop();
        logic ack;
        start_condition();
        send_byte({DEV_CODE, 3'd5, 1'b0}, ack);
        if (!ack)
            report_missing_ack("write control byte", {3'd5, 8'h5A});
        send_byte(8'h5A, ack);
        if (!ack)
            report_missing_ack("address byte", {3'd5, 8'h5A});
        stop_condition();
        verify_location({3'd5, 8'h5A});
        write_byte({3'd5, 8'h5A}, 8'h96);
        verify_location({3'd5, 8'h5A});
    endtask

    task automatic random_traffic();
        logic [ADDR_W-1:0] addrs [16];
        logic [7:0]        data;
        int                i;
        for (i = 0; i < 16; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            addrs[i]  = lcg_state[31:21];
            lcg_state = lcg_next(lcg_state);
            data      = lcg_state[31:24];
            write_byte(addrs[i], data);
        end
        for (i = 15; i >= 0; i--)
            verify_location(addrs[i]);
    endtask

    initial
    begin
        i2c_clk    = 1'b1;
        master_low = 1'b0;
        arst_n     = 1'b0;
        lcg_state  = LCG_SEED;
        repeat (16)
            @(posedge sda);
        #1;
        arst_n = 1'b1;
        wait_cycles(4);

        check_idle_release();
        write_then_read();
        block_bits_mapping();
        reject_wrong_code();
        abort_write_on_stop();
        random_traffic();

        $display("Value errors: %0d, acknowledge errors: %0d", value_errors, ack_errors);
        if ((value_errors == 0) && (ack_errors == 0))
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- eeprom_i2c.f
+incdir+tb
rtl/eeprom_pkg.sv
rtl/line_sync.sv
rtl/i2c_slave_fsm.sv
rtl/eeprom_mem.sv
rtl/eeprom_i2c_top.sv
tb/eeprom_i2c_tb.sv
